/* logic/displayPkg.sv */
package displayPkg;

    // ##################################################
    // Screen cells
    // ##################################################

    localparam int SymbolWidth = 8;  // Character code.
    localparam int AddrWidth = 8;    // Up to 256 cells.

    // Processor state shown as trace stop.
    localparam logic [2:0] DpcTraceState = 3'd2;

    // ##################################################
    // Display views
    // ##################################################

    typedef enum logic [2:0] {
        Restart = 3'd0,
        Iram    = 3'd1,
        Dram    = 3'd2,
        Cin     = 3'd3,
        Cout    = 3'd4
    } viewT;

endpackage

/* logic/keyboardPkg.sv */
package keyboardPkg;

    // Width of the front-panel key-state vector.
    localparam int KeyCount = 40;

    // ##################################################
    // View key positions
    // ##################################################

    localparam int IramKey = 32;
    localparam int DramKey = 33;
    localparam int CinKey = 34;
    localparam int CoutKey = 35;

    // Drops the display back to its startup view.
    localparam int HardResetKey = 39;

endpackage

/* logic/consoleWriter.sv */
`timescale 1ns/1ps

module consoleWriter #(
    parameter int Columns = 16,
    parameter int Rows = 10
) (
    input  logic                           Clk,
    input  logic                           reset,
    input  logic [displayPkg::SymbolWidth-1:0] symbol,
    input  logic                           cout,
    output logic                           cioAck,
    output logic                           wrReq,
    input  logic                           wrGnt,
    output logic [displayPkg::AddrWidth-1:0]   wrAddr,
    output logic [displayPkg::SymbolWidth-1:0] wrData
);
    import displayPkg::*;

    typedef enum logic {
        Idle,
        Store
    } stateT;

    localparam int Cells = Columns * Rows;
    localparam logic [AddrWidth-1:0] LastCell = AddrWidth'(Cells - 1);

    stateT state;
    logic [AddrWidth-1:0] cursor;
    logic newRequest;

    assign newRequest = (state == Idle) && cout && !cioAck;
    assign wrReq = (state == Store);  // Held until granted.
    assign wrAddr = cursor;

    always_ff @(posedge Clk) begin
        if (reset) begin
            state <= Idle;
            cioAck <= 1'b0;
            cursor <= '0;
        end else begin
            case (state)
                Idle: begin
                    if (newRequest) begin
                        state <= Store;
                    end else if (!cout) begin
                        cioAck <= 1'b0;  // Fourth phase.
                    end
                end
                Store: begin
                    if (wrGnt) begin
                        state <= Idle;
                        cioAck <= 1'b1;
                        cursor <= (cursor == LastCell) ? '0 : cursor + 1'b1;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (newRequest) begin
            wrData <= symbol;  // Captured with the request.
        end
    end

    // The CPU side must wait for the acknowledge to drop.
    assert property (@(posedge Clk) disable iff (reset) $rose(cout) |-> !cioAck);

endmodule

/* logic/frameStore.sv */
`timescale 1ns/1ps

module frameStore #(
    parameter int Columns = 16,
    parameter int Rows = 10
) (
    input  logic                           Clk,
    input  logic                           reset,
    input  logic                           wrReq,
    output logic                           wrGnt,
    input  logic [displayPkg::AddrWidth-1:0]   wrAddr,
    input  logic [displayPkg::SymbolWidth-1:0] wrData,
    input  logic                           rdReq,
    output logic                           rdGnt,
    input  logic [displayPkg::AddrWidth-1:0]   rdAddr,
    output logic [displayPkg::SymbolWidth-1:0] rdData
);
    import displayPkg::*;

    localparam int Cells = Columns * Rows;

    logic [SymbolWidth-1:0] cellMem [Cells];
    logic readWanted;

    initial begin
        for (int i = 0; i < Cells; i++) begin
            cellMem[i] = '0;
        end
    end

    // ##################################################
    // Scanner-first arbiter
    // ##################################################

    // A request still high during its own grant is not served twice.
    assign readWanted = rdReq && !rdGnt;

    always_ff @(posedge Clk) begin
        if (reset) begin
            rdGnt <= 1'b0;
            wrGnt <= 1'b0;
        end else begin
            rdGnt <= readWanted;
            wrGnt <= wrReq && !wrGnt && !readWanted;  // Writer only when scanner idle.
        end
    end

    // ##################################################
    // Cell memory
    // ##################################################

    always_ff @(posedge Clk) begin
        if (wrGnt) begin
            cellMem[wrAddr] <= wrData;
        end
        if (rdGnt) begin
            rdData <= cellMem[rdAddr];  // Valid the cycle after the grant.
        end
    end

    assert property (@(posedge Clk) disable iff (reset) !(wrGnt && rdGnt));

    assert property (@(posedge Clk) disable iff (reset)
        (wrReq |-> wrAddr < AddrWidth'(Cells)) and (rdReq |-> rdAddr < AddrWidth'(Cells)));

endmodule

/* logic/screenScanner.sv */
`timescale 1ns/1ps

module screenScanner #(
    parameter int Columns = 16,
    parameter int Rows = 10
) (
    input  logic                           Clk,
    input  logic                           reset,
    input  logic                           msTick,
    output logic                           rdReq,
    input  logic                           rdGnt,
    output logic [displayPkg::AddrWidth-1:0]   rdAddr,
    input  logic [displayPkg::SymbolWidth-1:0] rdData,
    output logic [displayPkg::AddrWidth-1:0]   address,
    output logic [displayPkg::SymbolWidth-1:0] dataN,
    output logic                           sweepDone
);
    import displayPkg::*;

    localparam int Cells = Columns * Rows;
    localparam logic [AddrWidth-1:0] LastCell = AddrWidth'(Cells - 1);

    logic dataReady;  // Read data arrives this cycle.

    assign rdAddr = address;

    // ##################################################
    // Cell sweep and fetch
    // ##################################################

    always_ff @(posedge Clk) begin
        if (reset) begin
            address <= '0;
            rdReq <= 1'b0;
            dataReady <= 1'b0;
            sweepDone <= 1'b0;
            dataN <= '1;  // Blank screen.
        end else begin
            sweepDone <= msTick && (address == LastCell);
            dataReady <= rdGnt;
            if (msTick) begin
                address <= (address == LastCell) ? '0 : address + 1'b1;
                rdReq <= 1'b1;
            end else if (rdGnt) begin
                rdReq <= 1'b0;
            end
            if (dataReady) begin
                dataN <= ~rdData;  // Scan board wants active-low codes.
            end
        end
    end

    // The whole fetch must finish between two ticks.
    assert property (@(posedge Clk) disable iff (reset)
        msTick |-> !(rdReq || rdGnt || dataReady));

endmodule

/* logic/viewSelector.sv */
`timescale 1ns/1ps

module viewSelector #(
    parameter int Columns = 16,
    parameter int Rows = 10
) (
    input  logic                           Clk,
    input  logic                           reset,
    input  logic                           msTick,
    input  logic                           sweepDone,
    input  logic [keyboardPkg::KeyCount-1:0] keys,
    input  logic [2:0]                     dpcState,
    output displayPkg::viewT               view,
    output logic                           marker
);
    import displayPkg::*;
    import keyboardPkg::*;

    localparam int Cells = Columns * Rows;

    viewT nextView;
    logic sweepSeen;                 // Wrap since the last tick.
    logic [AddrWidth:0] tickCount;   // Ticks since the last wrap.

    always_comb begin
        nextView = view;
        if (view == Restart) begin
            if (sweepSeen || sweepDone) nextView = Iram;
        end else if (keys[IramKey]) nextView = Iram;
        else if (keys[DramKey]) nextView = Dram;
        else if (keys[CinKey]) nextView = Cin;
        else if (keys[CoutKey]) nextView = Cout;
        else if (keys[HardResetKey]) nextView = Restart;
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            view <= Restart;
            sweepSeen <= 1'b0;
            tickCount <= '0;
        end else begin
            if (msTick) begin
                view <= nextView;
                sweepSeen <= 1'b0;
            end else if (sweepDone) begin
                sweepSeen <= 1'b1;
            end
            if (sweepDone) tickCount <= '0;
            else if (msTick) tickCount <= tickCount + 1'b1;
        end
    end

    assign marker = (view == Iram) && (dpcState == DpcTraceState);

    // A wrap reported by the scanner closes exactly one screen of ticks.
    assert property (@(posedge Clk) disable iff (reset)
        sweepDone |-> tickCount == (AddrWidth + 1)'(Cells));

endmodule

/* logic/ms6205Display.sv */
`timescale 1ns/1ps

module ms6205Display #(
    parameter int Columns = 16,
    parameter int Rows = 10
) (
    input  logic                           Clk,
    input  logic                           reset,
    input  logic                           msTick,
    input  logic [displayPkg::SymbolWidth-1:0] symbol,
    input  logic                           cout,
    output logic                           cioAck,
    output logic [displayPkg::AddrWidth-1:0]   address,
    output logic [displayPkg::SymbolWidth-1:0] dataN,
    input  logic [keyboardPkg::KeyCount-1:0] keys,
    input  logic [2:0]                     dpcState,
    output displayPkg::viewT               view,
    output logic                           marker
);
    import displayPkg::*;

    // ##################################################
    // Frame memory clients
    // ##################################################

    logic wrReq;
    logic wrGnt;
    logic [AddrWidth-1:0] wrAddr;
    logic [SymbolWidth-1:0] wrData;
    logic rdReq;
    logic rdGnt;
    logic [AddrWidth-1:0] rdAddr;
    logic [SymbolWidth-1:0] rdData;
    logic sweepDone;  // Scanner wrapped to cell 0.

    consoleWriter #(.Columns(Columns), .Rows(Rows)) i_consoleWriter (
        .Clk(Clk), .reset(reset), .symbol(symbol), .cout(cout), .cioAck(cioAck),
        .wrReq(wrReq), .wrGnt(wrGnt), .wrAddr(wrAddr), .wrData(wrData)
    );

    frameStore #(.Columns(Columns), .Rows(Rows)) i_frameStore (
        .Clk(Clk), .reset(reset),
        .wrReq(wrReq), .wrGnt(wrGnt), .wrAddr(wrAddr), .wrData(wrData),
        .rdReq(rdReq), .rdGnt(rdGnt), .rdAddr(rdAddr), .rdData(rdData)
    );

    screenScanner #(.Columns(Columns), .Rows(Rows)) i_screenScanner (
        .Clk(Clk), .reset(reset), .msTick(msTick),
        .rdReq(rdReq), .rdGnt(rdGnt), .rdAddr(rdAddr), .rdData(rdData),
        .address(address), .dataN(dataN), .sweepDone(sweepDone)
    );

    viewSelector #(.Columns(Columns), .Rows(Rows)) i_viewSelector (
        .Clk(Clk), .reset(reset), .msTick(msTick), .sweepDone(sweepDone),
        .keys(keys), .dpcState(dpcState), .view(view), .marker(marker)
    );

endmodule

/* sim/clockGen.sv */
`timescale 1ns/1ps

module clockGen #(
    parameter int Period = 40,
    parameter int ResetCycles = 2
) (
    output logic Clk,
    output logic reset
);

    initial begin
        Clk = 1'b0;
        forever #(Period / 2) Clk = ~Clk;
    end

    initial begin
        reset = 1'b1;
        repeat (ResetCycles) @(posedge Clk);
        reset <= 1'b0;  // Released on a rising edge.
    end

endmodule

/* sim/ms6205DisplayTb.sv */
`timescale 1ns/1ps

module ms6205DisplayTb;
    import displayPkg::*;
    import keyboardPkg::*;

    localparam int Columns = 16;
    localparam int Rows = 10;
    localparam int Cells = Columns * Rows;
    localparam int ClkPeriod = 40;
    localparam int Ticks = 520;
    localparam int Writes = 200;
    localparam int AckLimit = 10;
    localparam int HardResetTick = 250;  // Forced return to Restart.
    localparam int WatchdogTime = (Ticks + Writes) * 12 * ClkPeriod;

    logic Clk;
    logic reset;
    logic msTick;
    logic [SymbolWidth-1:0] symbol;
    logic cout;
    logic cioAck;
    logic [AddrWidth-1:0] address;
    logic [SymbolWidth-1:0] dataN;
    logic [KeyCount-1:0] keys;
    logic [2:0] dpcState;
    viewT view;
    logic marker;

    // Reference model state.
    logic [SymbolWidth-1:0] frame [Cells];
    int cursor;
    int modelAddr;
    viewT modelView;
    logic sweepFlag;  // Wrap seen since the last tick.

    clockGen #(.Period(ClkPeriod), .ResetCycles(2)) i_clockGen (.Clk(Clk), .reset(reset));

    ms6205Display #(.Columns(Columns), .Rows(Rows)) i_ms6205Display (
        .Clk(Clk), .reset(reset), .msTick(msTick), .symbol(symbol), .cout(cout),
        .cioAck(cioAck), .address(address), .dataN(dataN), .keys(keys),
        .dpcState(dpcState), .view(view), .marker(marker)
    );

    // ##################################################
    // Helpers
    // ##################################################

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic viewT predictView(input viewT current, input logic swept,
                                         input logic [KeyCount-1:0] pressed);
        if (current == Restart) return swept ? Iram : Restart;
        if (pressed[IramKey]) return Iram;
        if (pressed[DramKey]) return Dram;
        if (pressed[CinKey]) return Cin;
        if (pressed[CoutKey]) return Cout;
        if (pressed[HardResetKey]) return Restart;
        return current;
    endfunction

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            abortRun($sformatf("mismatch at %0d ns: %s expected %0h, actual %0h",
                               $time, name, expected, actual));
        end
    endtask

    // ##################################################
    // Console writes
    // ##################################################

    task automatic runConsole();
        logic [31:0] seed;
        logic [SymbolWidth-1:0] sym;
        int waited;
        seed = 32'd7978;
        for (int n = 0; n < Writes; n++) begin
            seed = xorshift(seed);
            sym = seed[SymbolWidth-1:0];
            repeat (seed[10:8]) @(posedge Clk);
            @(posedge Clk);
            symbol <= sym;
            cout <= 1'b1;
            waited = 0;
            @(negedge Clk);
            while (!cioAck) begin
                waited++;
                if (waited > AckLimit) begin
                    abortRun("cioAck did not rise within 10 cycles of cout");
                end
                @(negedge Clk);
            end
            frame[cursor] = sym;  // Stored once acknowledged.
            cursor = (cursor + 1) % Cells;
            @(posedge Clk);
            cout <= 1'b0;
            @(negedge Clk);
            checkValue("cioAck", 1, cioAck);
            @(negedge Clk);
            checkValue("cioAck", 0, cioAck);
        end
    endtask

    // ##################################################
    // Scan ticks and panel keys
    // ##################################################

    task automatic runScan();
        logic [31:0] seed;
        logic [KeyCount-1:0] keyBits;
        logic [2:0] dpc;
        logic [SymbolWidth-1:0] expectedData;
        logic expectedMarker;
        seed = ~32'd7978;  // Separate stream for the scan side.
        for (int t = 1; t <= Ticks; t++) begin
            seed = xorshift(seed);
            keyBits = '0;
            keyBits[31:0] = seed;
            seed = xorshift(seed);
            if (seed[1:0] == 2'd0) keyBits[KeyCount-1:32] = seed[15:8];
            if (t == HardResetTick) begin
                keyBits = '0;
                keyBits[HardResetKey] = 1'b1;
            end
            dpc = seed[16] ? DpcTraceState : seed[19:17];
            @(posedge Clk);
            msTick <= 1'b1;
            keys <= keyBits;
            dpcState <= dpc;
            modelView = predictView(modelView, sweepFlag, keyBits);
            sweepFlag = (modelAddr == Cells - 1);
            modelAddr = (modelAddr + 1) % Cells;
            expectedMarker = (modelView == Iram) && (dpc == DpcTraceState);
            @(posedge Clk);
            msTick <= 1'b0;
            @(negedge Clk);
            checkValue("view", modelView, view);
            checkValue("marker", expectedMarker, marker);
            repeat (2) @(negedge Clk);
            expectedData = ~frame[modelAddr];  // Cell as seen at the read grant.
            @(negedge Clk);
            checkValue("address", modelAddr, address);
            checkValue("dataN", expectedData, dataN);
            checkValue("marker", expectedMarker, marker);
            repeat (3 + seed[21:20]) @(posedge Clk);
        end
    endtask

    initial begin
        msTick = 1'b0;
        symbol = '0;
        cout = 1'b0;
        keys = '0;
        dpcState = '0;
        for (int i = 0; i < Cells; i++) begin
            frame[i] = '0;
        end
        cursor = 0;
        modelAddr = 0;
        modelView = Restart;
        sweepFlag = 1'b0;
        wait (reset === 1'b0);
        @(negedge Clk);
        checkValue("cioAck", 0, cioAck);
        checkValue("marker", 0, marker);
        checkValue("address", 0, address);
        checkValue("dataN", 8'hff, dataN);
        checkValue("view", Restart, view);
        fork
            runConsole();
            runScan();
        join
        $display("Test completed successfully");
        $finish;
    end

    initial begin
        #(WatchdogTime);
        abortRun("The run timed out before all ticks and writes were done");
    end

endmodule

/* flist.f */
logic/displayPkg.sv
logic/keyboardPkg.sv
logic/consoleWriter.sv
logic/frameStore.sv
logic/screenScanner.sv
logic/viewSelector.sv
logic/ms6205Display.sv
sim/clockGen.sv
sim/ms6205DisplayTb.sv

/* Bender.yml */
package:
  name: ms6205Display

dependencies: {}

sources:
  # Packages first, then the blocks and the top level.
  - logic/displayPkg.sv
  - logic/keyboardPkg.sv
  - logic/consoleWriter.sv
  - logic/frameStore.sv
  - logic/screenScanner.sv
  - logic/viewSelector.sv
  - logic/ms6205Display.sv

  - target: test
    files:
      - sim/clockGen.sv
      - sim/ms6205DisplayTb.sv
